//--- Bender.yml
package:
  name: core_top

sources:
  - design/core_pkg.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/fetch_stage.sv
  - design/execute_stage.sv
  - design/hazard_unit.sv
  - design/writeback_stage.sv
  - design/core_top.sv
  - target: simulation
    files:
      - testbench/core_tb.sv

//--- core_top.f
design/core_pkg.sv
design/alu.sv
design/reg_file.sv
design/fetch_stage.sv
design/execute_stage.sv
design/hazard_unit.sv
design/writeback_stage.sv
design/core_top.sv
testbench/core_tb.sv

//--- design/alu.sv
/*
 * integer ALU, purely combinational
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  core_pkg::alu_op_t alu_op,
    input  core_pkg::word_t   port_a,
    input  core_pkg::word_t   port_b,
    output core_pkg::word_t   port_out
);
    import core_pkg::*;

    logic [4:0] shamt;

    // shift amount from the low five bits
    assign shamt = port_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: port_out = port_a + port_b;
            ALU_SUB: port_out = port_a - port_b;
            ALU_AND: port_out = port_a & port_b;
            ALU_OR:  port_out = port_a | port_b;
            ALU_XOR: port_out = port_a ^ port_b;
            // signed compare
            ALU_SLT: port_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ALU_SLL: port_out = port_a << shamt;
            ALU_SRL: port_out = port_a >> shamt;
            default: port_out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/core_pkg.sv
/*
 * core package for the three-stage RV32I pipeline
 * word and index types, opcode and ALU enums, pipeline records
 */
`default_nettype none

package core_pkg;

    // basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    // first fetch address
    localparam word_t RESET_PC  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;
    // only SYSTEM encoding accepted, used as halt
    localparam word_t EBREAK_INSTR = 32'h0010_0073;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t pc4;
        word_t instr;
    } fetch_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
        word_t    pc;
        logic     illegal;
        logic     halt;
    } ex_wb_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_write;
        logic     illegal;
    } retire_t;

endpackage

`default_nettype wire

//--- design/core_top.sv
/*
 * three-stage RV32I core
 * fetch, execute and writeback around a shared register file
 */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic              CLK,
    input  logic              nRST,
    output core_pkg::word_t   imem_addr,
    input  core_pkg::word_t   imem_rdata,
    output logic              retire_valid,
    output core_pkg::retire_t retire,
    output logic              halted
);
    import core_pkg::*;

    // stage registers
    fetch_ex_t fetch_ex;
    ex_wb_t    ex_wb;

    // control between stages
    logic      redirect, halt_e;
    word_t     redirect_pc;
    logic      fwd_rs1, fwd_rs2, fe_flush, fe_stall;

    // register file ports
    reg_idx_t  rs1, rs2, rf_rd;
    word_t     rs1_data, rs2_data, rf_wdata;
    logic      rf_wen;

    fetch_stage fetch0 (
        .CLK, .nRST,
        .redirect, .redirect_pc,
        .fe_flush, .fe_stall,
        .imem_addr, .imem_rdata,
        .fetch_ex
    );

    execute_stage execute0 (
        .CLK, .nRST,
        .fetch_ex,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .fwd_rs1, .fwd_rs2,
        .ex_wb,
        .redirect, .redirect_pc, .halt_e
    );

    writeback_stage writeback0 (
        .CLK, .nRST,
        .ex_wb,
        .rf_wen, .rf_rd, .rf_wdata,
        .retire_valid, .retire, .halted
    );

    reg_file rf0 (
        .CLK, .nRST,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .wen  (rf_wen),
        .rd   (rf_rd),
        .wdata(rf_wdata)
    );

    hazard_unit hazard0 (
        .rs1_e(rs1),
        .rs2_e(rs2),
        .ex_wb,
        .redirect, .halt_e,
        .fwd_rs1, .fwd_rs2,
        .fe_flush, .fe_stall
    );

endmodule

`default_nettype wire

//--- design/execute_stage.sv
/*
 * execute stage
 * decode, operand forwarding, ALU, branch and jump resolution,
 * and the execute/writeback register
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  core_pkg::fetch_ex_t fetch_ex,
    output core_pkg::reg_idx_t  rs1,
    output core_pkg::reg_idx_t  rs2,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                fwd_rs1,
    input  logic                fwd_rs2,
    output core_pkg::ex_wb_t    ex_wb,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output logic                halt_e
);
    import core_pkg::*;

    word_t    instr;
    opcode_t  opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t  alu_op;
    logic     use_imm, reg_write, illegal, halt;
    logic     is_branch, is_jal, is_jalr, is_lui;
    logic     ok, branch_taken, halt_done;
    word_t    imm_i, imm_u, imm_b, imm_j;
    word_t    rs1_val, rs2_val, alu_b, alu_out, result;

    assign instr  = fetch_ex.instr;
    assign opc    = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // decode
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        illegal   = 1'b0;
        halt      = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_lui    = 1'b0;
        case (opc)
            OPC_OP: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    10'b0000000_001: alu_op = ALU_SLL;
                    10'b0000000_101: alu_op = ALU_SRL;
                    default:         illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b010:  alu_op = ALU_SLT;
                    // immediate shifts not supported
                    default: illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                reg_write = 1'b1;
                is_lui    = 1'b1;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                // beq and bne only
                illegal   = (funct3[2:1] != 2'b00);
            end
            OPC_JAL: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
            end
            OPC_JALR: begin
                reg_write = 1'b1;
                is_jalr   = 1'b1;
                illegal   = (funct3 != 3'b000);
            end
            OPC_SYSTEM: begin
                halt    = (instr == EBREAK_INSTR);
                illegal = (instr != EBREAK_INSTR);
            end
            default: illegal = 1'b1;
        endcase
    end

    // live instruction with side effects
    assign ok = fetch_ex.valid && !illegal;

    // forwarded operands
    assign rs1_val = fwd_rs1 ? ex_wb.result : rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb.result : rs2_data;
    assign alu_b   = use_imm ? imm_i : rs2_val;

    alu alu0 (
        .alu_op  (alu_op),
        .port_a  (rs1_val),
        .port_b  (alu_b),
        .port_out(alu_out)
    );

    // funct3[0] picks bne over beq
    assign branch_taken = is_branch && (funct3[0] ? (rs1_val != rs2_val) : (rs1_val == rs2_val));

    // jalr clears bit zero of the sum
    always_comb begin
        if (is_jalr) begin
            redirect_pc = (rs1_val + imm_i) & ~32'd1;
        end else if (is_jal) begin
            redirect_pc = fetch_ex.pc + imm_j;
        end else begin
            redirect_pc = fetch_ex.pc + imm_b;
        end
    end

    assign redirect = ok && (branch_taken || is_jal || is_jalr);
    assign halt_e   = ok && halt;

    // link value for jumps
    assign result = is_lui ? imm_u : ((is_jal || is_jalr) ? fetch_ex.pc4 : alu_out);

    // execute/writeback register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_wb     <= '0;
            halt_done <= 1'b0;
        end else begin
            // frozen halt must retire only once
            ex_wb.valid     <= fetch_ex.valid && !halt_done;
            ex_wb.reg_write <= ok && reg_write && !halt_done;
            ex_wb.rd        <= instr[11:7];
            ex_wb.result    <= result;
            ex_wb.pc        <= fetch_ex.pc;
            ex_wb.illegal   <= fetch_ex.valid && illegal;
            ex_wb.halt      <= halt_e && !halt_done;
            halt_done       <= halt_done || halt_e;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
/*
 * fetch stage
 * program counter with redirect and halt stall, feeds the fetch/execute register
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    input  logic            fe_flush,
    input  logic            fe_stall,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_rdata,
    output core_pkg::fetch_ex_t fetch_ex
);
    import core_pkg::*;

    word_t pc;
    word_t pc4;

    assign pc4       = pc + 32'd4;
    // memory answers in the same cycle
    assign imem_addr = pc;

    // program counter
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!fe_stall) begin
            pc <= pc4;
        end
    end

    // fetch/execute register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '{valid: 1'b0, pc: RESET_PC, pc4: RESET_PC, instr: NOP_INSTR};
        end else if (fe_flush) begin
            // squash the wrong-path instruction
            fetch_ex <= '{valid: 1'b0, pc: pc, pc4: pc4, instr: NOP_INSTR};
        end else if (!fe_stall) begin
            fetch_ex <= '{valid: 1'b1, pc: pc, pc4: pc4, instr: imem_rdata};
        end
        // stalled: hold
    end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
/*
 * forwarding and hazard control
 * forwards from ex_wb, flushes fetch on redirect, freezes on halt
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  core_pkg::reg_idx_t rs1_e,
    input  core_pkg::reg_idx_t rs2_e,
    input  core_pkg::ex_wb_t   ex_wb,
    input  logic               redirect,
    input  logic               halt_e,
    output logic               fwd_rs1,
    output logic               fwd_rs2,
    output logic               fe_flush,
    output logic               fe_stall
);

    logic wb_writes;

    // a live producer in writeback, x0 never forwarded
    assign wb_writes = ex_wb.valid && ex_wb.reg_write && (ex_wb.rd != '0);

    assign fwd_rs1 = wb_writes && (ex_wb.rd == rs1_e);
    assign fwd_rs2 = wb_writes && (ex_wb.rd == rs2_e);

    // one wrong-path slot behind a taken branch or jump
    assign fe_flush = redirect;
    // halt in execute freezes fetch for good
    assign fe_stall = halt_e;

endmodule

`default_nettype wire

//--- design/reg_file.sv
/*
 * 32x32 register file, x0 reads as zero
 * two asynchronous read ports, one write port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               CLK,
    input  logic               nRST,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  logic               wen,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    wdata
);
    import core_pkg::*;

    // no storage behind x0
    word_t regs [31:1];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // write lands after the edge, forwarding covers the same cycle
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
/*
 * writeback stage
 * register-file write, retire record and sticky halted flag
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  core_pkg::ex_wb_t   ex_wb,
    output logic               rf_wen,
    output core_pkg::reg_idx_t rf_rd,
    output core_pkg::word_t    rf_wdata,
    output logic               retire_valid,
    output core_pkg::retire_t  retire,
    output logic               halted
);

    // register write at the end of the retire cycle
    assign rf_wen   = ex_wb.valid && ex_wb.reg_write;
    assign rf_rd    = ex_wb.rd;
    assign rf_wdata = ex_wb.result;

    // every valid instruction retires, illegal ones too
    assign retire_valid = ex_wb.valid;
    assign retire = '{
        pc:        ex_wb.pc,
        rd:        ex_wb.rd,
        wdata:     ex_wb.result,
        reg_write: rf_wen,
        illegal:   ex_wb.illegal
    };

    // set the cycle after halt retires, held until reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halted <= 1'b0;
        end else if (ex_wb.valid && ex_wb.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/core_tb.sv
/*
 * testbench for the three-stage RV32I core
 * runs a fixed program and checks every retire against an ISA model
 */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int MEM_WORDS  = 128;
    localparam int RAND_COUNT = 24;

    logic    CLK;
    logic    nRST;
    word_t   imem_addr;
    word_t   imem_rdata;
    logic    retire_valid;
    retire_t retire;
    logic    halted;

    word_t       prog [MEM_WORDS];
    int          prog_len;
    logic [31:0] lfsr;

    // architectural model
    word_t   m_pc;
    word_t   m_regs [32];
    logic    m_halted;
    retire_t expected;

    int      retired;
    int      value_errors;
    int      other_errors;
    int      cycles;
    int      timeout;

    core_top dut0 (
        .CLK, .nRST,
        .imem_addr, .imem_rdata,
        .retire_valid, .retire, .halted
    );

    // combinational instruction memory returning nop past the program
    assign imem_rdata = (imem_addr[31:2] < prog_len) ? prog[imem_addr[31:2]] : NOP_INSTR;

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic emit(input word_t instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    task automatic build_program();
        int         p;
        logic [1:0] kind;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [11:0] imm;
        // dependent alu chain with x0 and signed slt
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(i_type(12'hff4, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(r_type(7'h00, 5'd1, 5'd4, 3'b010, 5'd5));
        emit(i_type(12'hfff, 5'd1, 3'b010, 5'd6, OPC_OP_IMM));
        emit(i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
        // x0 in writeback must not be forwarded
        emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd7));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd8));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b110, 5'd9));
        emit(r_type(7'h00, 5'd2, 5'd9, 3'b100, 5'd10));
        emit(i_type(12'h0f0, 5'd2, 3'b111, 5'd11, OPC_OP_IMM));
        emit(i_type(12'h801, 5'd1, 3'b110, 5'd12, OPC_OP_IMM));
        emit(i_type(12'h5a5, 5'd12, 3'b100, 5'd13, OPC_OP_IMM));
        // lui and shifts with the last amount above 31
        emit(u_type(20'habcde, 5'd14));
        emit(i_type(12'd4, 5'd0, 3'b000, 5'd15, OPC_OP_IMM));
        emit(r_type(7'h00, 5'd15, 5'd14, 3'b001, 5'd16));
        emit(r_type(7'h00, 5'd15, 5'd14, 3'b101, 5'd17));
        emit(i_type(12'd35, 5'd0, 3'b000, 5'd18, OPC_OP_IMM));
        emit(r_type(7'h00, 5'd18, 5'd14, 3'b101, 5'd19));
        // each taken branch is followed by a wrong-path addi
        emit(b_type(13'd8, 5'd7, 5'd1, 3'b000));
        emit(i_type(12'd99, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
        emit(i_type(12'd98, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));
        emit(j_type(21'd8, 5'd21));
        emit(i_type(12'd97, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
        // jalr target with bit zero set and a forwarded base
        p = prog_len;
        emit(i_type(12'((p + 3) * 4 + 1), 5'd0, 3'b000, 5'd22, OPC_OP_IMM));
        emit(i_type(12'd0, 5'd22, 3'b000, 5'd23, OPC_JALR));
        emit(i_type(12'd96, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
        emit(r_type(7'h00, 5'd23, 5'd21, 3'b000, 5'd24));
        // illegal slli, all ones, blt and ecall
        emit(i_type(12'd1, 5'd1, 3'b001, 5'd1, OPC_OP_IMM));
        emit(32'hffff_ffff);
        emit(b_type(13'd8, 5'd0, 5'd0, 3'b100));
        emit(32'h0000_0073);
        // x1 must be untouched
        emit(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd25));
        for (int k = 0; k < RAND_COUNT; k++) begin
            kind = 2'(take_bits(2));
            rd   = reg_idx_t'(take_bits(5));
            rs1  = reg_idx_t'(take_bits(5));
            rs2  = reg_idx_t'(take_bits(5));
            imm  = 12'(take_bits(12));
            if (kind == 2'd0) begin
                emit(r_type(7'h00, rs2, rs1, 3'b000, rd));
            end else if (kind == 2'd1) begin
                emit(r_type(7'h00, rs2, rs1, 3'b100, rd));
            end else begin
                emit(i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM));
            end
        end
        emit(EBREAK_INSTR);
        // never retire
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    endtask

    // one instruction of the ISA model returning the expected retire
    function automatic retire_t step_model();
        word_t   instr;
        word_t   a;
        word_t   b;
        word_t   imm_i;
        word_t   next_pc;
        retire_t exp;
        instr   = prog[m_pc[31:2]];
        a       = m_regs[instr[19:15]];
        b       = m_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        next_pc = m_pc + 32'd4;
        exp     = '{pc: m_pc, rd: instr[11:7], wdata: '0, reg_write: 1'b0, illegal: 1'b0};
        case (instr[6:0])
            OPC_OP: begin
                exp.reg_write = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: exp.wdata = a + b;
                    10'b0100000_000: exp.wdata = a - b;
                    10'b0000000_111: exp.wdata = a & b;
                    10'b0000000_110: exp.wdata = a | b;
                    10'b0000000_100: exp.wdata = a ^ b;
                    10'b0000000_010: exp.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'b0000000_001: exp.wdata = a << b[4:0];
                    10'b0000000_101: exp.wdata = a >> b[4:0];
                    default: begin
                        exp.reg_write = 1'b0;
                        exp.illegal   = 1'b1;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                exp.reg_write = 1'b1;
                case (instr[14:12])
                    3'b000: exp.wdata = a + imm_i;
                    3'b111: exp.wdata = a & imm_i;
                    3'b110: exp.wdata = a | imm_i;
                    3'b100: exp.wdata = a ^ imm_i;
                    3'b010: exp.wdata = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                    default: begin
                        exp.reg_write = 1'b0;
                        exp.illegal   = 1'b1;
                    end
                endcase
            end
            OPC_LUI: begin
                exp.reg_write = 1'b1;
                exp.wdata     = {instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                if (instr[14:13] != 2'b00) begin
                    exp.illegal = 1'b1;
                end else if ((a == b) != instr[12]) begin
                    // bit 12 turns beq into bne
                    next_pc = m_pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                      instr[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                exp.reg_write = 1'b1;
                exp.wdata     = m_pc + 32'd4;
                next_pc = m_pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (instr[14:12] == 3'b000) begin
                    exp.reg_write = 1'b1;
                    exp.wdata     = m_pc + 32'd4;
                    next_pc       = (a + imm_i) & ~32'd1;
                end else begin
                    exp.illegal = 1'b1;
                end
            end
            OPC_SYSTEM: begin
                if (instr == EBREAK_INSTR) begin
                    m_halted = 1'b1;
                end else begin
                    exp.illegal = 1'b1;
                end
            end
            default: exp.illegal = 1'b1;
        endcase
        if (exp.reg_write && exp.rd != 5'd0) begin
            m_regs[exp.rd] = exp.wdata;
        end
        m_pc = next_pc;
        return exp;
    endfunction

    // rd and wdata only matter when the instruction writes
    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc) begin
            $display("Fail retire.pc: got %h expected %h", got.pc, exp.pc);
            value_errors++;
        end
        if (got.reg_write !== exp.reg_write) begin
            $display("Fail retire.reg_write: got %h expected %h at pc %h",
                     got.reg_write, exp.reg_write, exp.pc);
            value_errors++;
        end
        if (got.illegal !== exp.illegal) begin
            $display("Fail retire.illegal: got %h expected %h at pc %h",
                     got.illegal, exp.illegal, exp.pc);
            value_errors++;
        end
        if (exp.reg_write && (got.rd !== exp.rd || got.wdata !== exp.wdata)) begin
            $display("Fail retire.rd/wdata: got %h/%h expected %h/%h at pc %h",
                     got.rd, got.wdata, exp.rd, exp.wdata, exp.pc);
            value_errors++;
        end
    endtask

    task automatic check_halted(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail halted: got %h expected %h", got, exp);
            value_errors++;
        end
    endtask

    // compare mid-cycle where retire outputs are settled
    always @(negedge CLK) begin
        check_halted(halted, m_halted);
        if (retire_valid === 1'b1) begin
            if (m_halted) begin
                $display("a retire appeared after the halt instruction, pc %h", retire.pc);
                other_errors++;
            end else begin
                expected = step_model();
                check_retire(retire, expected);
                retired++;
            end
        end
    end

    initial begin
        lfsr         = 32'h15b0f962;
        prog_len     = 0;
        m_pc         = RESET_PC;
        m_halted     = 1'b0;
        retired      = 0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        nRST = 1'b0;
        build_program();
        timeout = prog_len * 3 + 20;
        repeat (3) @(posedge CLK);
        #1 nRST = 1'b1;
        while (halted !== 1'b1 && cycles < timeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout after %0d cycles, halted never rose", cycles);
            other_errors++;
        end else begin
            // idle cycles to catch stray retires
            repeat (4) @(negedge CLK);
        end
        // the compare of the last falling edge completes first
        @(posedge CLK);
        if (!m_halted) begin
            $display("the model never reached the halt instruction");
            other_errors++;
        end
        $display("retired %0d, value errors %0d, other errors %0d",
                 retired, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
